/* Makefile */
# Verilator build and run for the MCI subsystem testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mci_top_tb
FILELIST  = mci_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run log decides the result, not the simulator exit code
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/cif_if.sv */
////////////////////
// Internal fabric interface
// Simplex request/response bus with dv/hold handshake
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface cif_if;
    import mci_pkg::*;

    // Request fields, stable while hold is high
    logic  dv;
    logic  write;
    addr_t addr;
    data_t wdata;
    user_t user;

    // Response fields, valid in the cycle dv & !hold
    logic  hold;
    data_t rdata;
    logic  error;

    // Requester side
    modport request (
        output dv,
        output write,
        output addr,
        output wdata,
        output user,
        input  hold,
        input  rdata,
        input  error
    );

    // Target side
    modport response (
        input  dv,
        input  write,
        input  addr,
        input  wdata,
        input  user,
        output hold,
        output rdata,
        output error
    );

endinterface

`default_nettype wire

/* common/mci_pkg.sv */
////////////////////
// MCI shared definitions
// Fabric widths, watchdog period type, CSR offsets
// and the subsystem address map
////////////////////
`default_nettype none

package mci_pkg;

    // Fabric widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int USER_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [USER_W-1:0] user_t;

    // Watchdog timeout period, in clock cycles
    typedef logic [31:0] period_t;

    // CSR window
    localparam addr_t REG_BASE = 32'h0000_0000;
    localparam addr_t REG_SIZE = 32'h0000_1000;

    // MCU SRAM window, size set by MCU_SRAM_SIZE_KB
    localparam addr_t SRAM_BASE = 32'h0001_0000;

    // CSR byte offsets
    localparam addr_t WDT_T1_EN_OFS      = 32'h00;
    localparam addr_t WDT_T1_CTRL_OFS    = 32'h04;
    localparam addr_t WDT_T1_PERIOD_OFS  = 32'h08;
    localparam addr_t WDT_T2_CTRL_OFS    = 32'h0C;
    localparam addr_t WDT_T2_PERIOD_OFS  = 32'h10;
    localparam addr_t WDT_STATUS_OFS     = 32'h14;
    localparam addr_t FW_EXEC_SIZE_OFS   = 32'h18;
    localparam addr_t HW_ERROR_FATAL_OFS = 32'h1C;

    // Word address width of an SRAM of size_kb kilobytes
    function automatic int sram_addr_w(int size_kb);
        return $clog2(size_kb * 256);
    endfunction

endpackage

`default_nettype wire

/* mci_mcu_sram/mci_mcu_sram_ctrl.sv */
////////////////////
// MCU SRAM controller
// Forwards fabric accesses to the SRAM port and
// guards the FW execution region while locked
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mci_mcu_sram_ctrl #(
    parameter  int MCU_SRAM_SIZE_KB = 4,
    localparam int SRAM_ADDR_W      = mci_pkg::sram_addr_w(MCU_SRAM_SIZE_KB)
) (
    input  logic                   clk,
    input  logic                   reset,

    // Protection controls
    input  mci_pkg::data_t         fw_exec_size,
    input  logic                   mcu_req,
    input  logic                   mcu_sram_fw_exec_region_lock,

    // Fabric target port
    cif_if.response                cif_resp_if,

    // SRAM port
    output logic                   sram_cs,
    output logic                   sram_we,
    output logic [SRAM_ADDR_W-1:0] sram_addr,
    output mci_pkg::data_t         sram_wdata,
    input  mci_pkg::data_t         sram_rdata
);
    import mci_pkg::*;

    typedef enum logic {
        IDLE,
        RESP
    } state_e;

    state_e state_q;
    state_e state_d;
    addr_t  ofs;
    logic   in_exec_region;
    logic   refuse;

    // Byte offset inside the SRAM window
    assign ofs = cif_resp_if.addr - SRAM_BASE;

    // KB index below the region size
    assign in_exec_region = {10'd0, ofs[31:10]} < fw_exec_size;
    assign refuse = mcu_sram_fw_exec_region_lock & ~mcu_req & in_exec_region;

    // Word address and data straight from the request
    assign sram_addr  = ofs[SRAM_ADDR_W+1:2];
    assign sram_wdata = cif_resp_if.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d           = state_q;
        sram_cs           = 1'b0;
        sram_we           = 1'b0;
        cif_resp_if.hold  = 1'b0;
        cif_resp_if.error = 1'b0;
        cif_resp_if.rdata = '0;
        case (state_q)
            IDLE: begin
                if (cif_resp_if.dv) begin
                    if (refuse) begin
                        // Refused, no SRAM access
                        cif_resp_if.error = 1'b1;
                    end else if (cif_resp_if.write) begin
                        sram_cs = 1'b1;
                        sram_we = 1'b1;
                    end else begin
                        // Read, stall one cycle for the SRAM
                        sram_cs          = 1'b1;
                        cif_resp_if.hold = 1'b1;
                        state_d          = RESP;
                    end
                end
            end
            RESP: begin
                cif_resp_if.rdata = sram_rdata;
                state_d           = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* mci_reg/mci_reg_top.sv */
////////////////////
// MCI CSR bank
// Watchdog controls, FW exec region size and
// fatal error latch, privilege-checked writes
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mci_reg_top (
    input  logic             clk,
    input  logic             reset,

    // Fabric target port
    cif_if.response          cif_resp_if,

    // Requester class from the decoder
    input  logic             mcu_req,
    input  logic             clp_req,

    // Watchdog controls
    output logic             t1_en,
    output logic             t1_restart,
    output logic             t2_restart,
    output mci_pkg::period_t t1_period,
    output mci_pkg::period_t t2_period,
    output logic             t1_serviced,
    output logic             t2_serviced,

    // Watchdog status
    input  logic             t1_timeout,
    input  logic             t2_timeout,
    input  logic             t2_timeout_p,

    // MCU SRAM protection size, KB
    output mci_pkg::data_t   fw_exec_size,

    output logic             error_fatal
);
    import mci_pkg::*;

    addr_t ofs;
    logic  priv;
    logic  wr_req;
    logic  wr_ok;
    logic  fatal_clr;

    // Offset inside the CSR window
    assign ofs = cif_resp_if.addr - REG_BASE;

    // Only MCU or CLP may write
    assign priv   = mcu_req | clp_req;
    assign wr_req = cif_resp_if.dv & cif_resp_if.write;
    assign wr_ok  = wr_req & priv;

    // Single cycle target
    assign cif_resp_if.hold  = 1'b0;
    assign cif_resp_if.error = wr_req & ~priv;

    // Self-clearing restart pulses
    assign t1_restart = wr_ok & (ofs == WDT_T1_CTRL_OFS) & cif_resp_if.wdata[0];
    assign t2_restart = wr_ok & (ofs == WDT_T2_CTRL_OFS) & cif_resp_if.wdata[0];

    // W1C on status is the serviced pulse
    assign t1_serviced = wr_ok & (ofs == WDT_STATUS_OFS) & cif_resp_if.wdata[0];
    assign t2_serviced = wr_ok & (ofs == WDT_STATUS_OFS) & cif_resp_if.wdata[1];

    assign fatal_clr = wr_ok & (ofs == HW_ERROR_FATAL_OFS) & cif_resp_if.wdata[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            t1_en        <= 1'b0;
            t1_period    <= '1;
            t2_period    <= '1;
            fw_exec_size <= '0;
            error_fatal  <= 1'b0;
        end else begin
            if (wr_ok) begin
                case (ofs)
                    WDT_T1_EN_OFS:     t1_en        <= cif_resp_if.wdata[0];
                    WDT_T1_PERIOD_OFS: t1_period    <= period_t'(cif_resp_if.wdata);
                    WDT_T2_PERIOD_OFS: t2_period    <= period_t'(cif_resp_if.wdata);
                    FW_EXEC_SIZE_OFS:  fw_exec_size <= cif_resp_if.wdata;
                    default: ;
                endcase
            end
            // Fatal latch, a new timeout wins over the clear
            if (t2_timeout_p) begin
                error_fatal <= 1'b1;
            end else if (fatal_clr) begin
                error_fatal <= 1'b0;
            end
        end
    end

    // Read mux, open to every user
    always_comb begin
        case (ofs)
            WDT_T1_EN_OFS:      cif_resp_if.rdata = {31'd0, t1_en};
            WDT_T1_PERIOD_OFS:  cif_resp_if.rdata = data_t'(t1_period);
            WDT_T2_PERIOD_OFS:  cif_resp_if.rdata = data_t'(t2_period);
            WDT_STATUS_OFS:     cif_resp_if.rdata = {30'd0, t2_timeout, t1_timeout};
            FW_EXEC_SIZE_OFS:   cif_resp_if.rdata = fw_exec_size;
            HW_ERROR_FATAL_OFS: cif_resp_if.rdata = {31'd0, error_fatal};
            // Control pulses and holes read zero
            default:            cif_resp_if.rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* mci_top.f */
common/mci_pkg.sv
common/cif_if.sv
source/mci_fabric_decode.sv
mci_reg/mci_reg_top.sv
mci_wdt/mci_wdt_top.sv
mci_mcu_sram/mci_mcu_sram_ctrl.sv
source/mci_top.sv
tb/mci_top_props.sv
tb/mci_top_tb.sv

/* mci_wdt/mci_wdt_top.sv */
////////////////////
// MCI watchdog
// Two cascaded timers, stage 2 runs while stage 1
// sits in timeout, stage 2 expiry is fatal
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mci_wdt_top (
    input  logic             clk,
    input  logic             reset,

    // Controls from the CSR bank
    input  logic             t1_en,
    input  logic             t1_restart,
    input  logic             t2_restart,
    input  mci_pkg::period_t t1_period,
    input  mci_pkg::period_t t2_period,
    input  logic             t1_serviced,
    input  logic             t2_serviced,

    // Status
    output logic             t1_timeout,
    output logic             t2_timeout,
    output logic             t2_timeout_p,
    output logic             fatal_timeout
);
    import mci_pkg::*;

    period_t t1_cnt;
    period_t t2_cnt;
    logic    t1_run;
    logic    t2_run;
    logic    t1_expire;

    // Stage 1 runs when enabled and not yet expired
    assign t1_run    = t1_en & ~t1_timeout;
    assign t1_expire = t1_run & (t1_cnt == t1_period);

    // Cascade, stage 2 only while stage 1 is unserviced
    assign t2_run       = t1_timeout & ~t2_timeout;
    assign t2_timeout_p = t2_run & (t2_cnt == t2_period);

    always_ff @(posedge clk) begin
        if (reset) begin
            t1_cnt        <= '0;
            t2_cnt        <= '0;
            t1_timeout    <= 1'b0;
            t2_timeout    <= 1'b0;
            fatal_timeout <= 1'b0;
        end else begin
            // Stage 1 counter
            if (t1_restart || !t1_run || t1_expire) begin
                t1_cnt <= '0;
            end else begin
                t1_cnt <= t1_cnt + 1'b1;
            end

            // Stage 1 sticky timeout
            if (t1_expire) begin
                t1_timeout <= 1'b1;
            end else if (t1_serviced) begin
                t1_timeout <= 1'b0;
            end

            // Stage 2 counter
            if (t2_restart || !t2_run || t2_timeout_p) begin
                t2_cnt <= '0;
            end else begin
                t2_cnt <= t2_cnt + 1'b1;
            end

            // Stage 2 sticky timeout
            if (t2_timeout_p) begin
                t2_timeout <= 1'b1;
            end else if (t2_serviced) begin
                t2_timeout <= 1'b0;
            end

            // Fatal flag, cleared only by reset
            if (t2_timeout_p) begin
                fatal_timeout <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/mci_fabric_decode.sv */
////////////////////
// MCI fabric decoder
// Routes requests to the CSR bank or MCU SRAM,
// errors unmapped addresses, classifies users
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mci_fabric_decode #(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  logic           clk,
    input  logic           reset,

    // Upstream fabric request
    input  logic           req_dv,
    input  logic           req_write,
    input  mci_pkg::addr_t req_addr,
    input  mci_pkg::data_t req_wdata,
    input  mci_pkg::user_t req_user,
    output logic           req_hold,
    output mci_pkg::data_t req_rdata,
    output logic           req_error,

    // Privileged user straps
    input  mci_pkg::user_t strap_mcu_user,
    input  mci_pkg::user_t strap_clp_user,

    // Target ports
    cif_if.request         reg_req_if,
    cif_if.request         sram_req_if,

    // Requester class
    output logic           mcu_req,
    output logic           clp_req
);
    import mci_pkg::*;

    localparam addr_t SRAM_SIZE = addr_t'(MCU_SRAM_SIZE_KB * 1024);

    logic reg_hit;
    logic sram_hit;
    logic sel_reg;
    logic sel_sram;
    // Target of a stalled request
    logic stall_q;
    logic stall_sram_q;

    // Window checks via offset, base may be zero
    assign reg_hit  = (req_addr - REG_BASE) < REG_SIZE;
    assign sram_hit = (req_addr - SRAM_BASE) < SRAM_SIZE;

    // Keep the mux on the stalled target until completion
    assign sel_reg  = stall_q ? ~stall_sram_q : reg_hit;
    assign sel_sram = stall_q ? stall_sram_q : sram_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_q      <= 1'b0;
            stall_sram_q <= 1'b0;
        end else begin
            stall_q <= req_dv & req_hold;
            if (req_dv & req_hold) begin
                stall_sram_q <= sel_sram;
            end
        end
    end

    // Straps compare
    assign mcu_req = (req_user == strap_mcu_user);
    assign clp_req = (req_user == strap_clp_user);

    // CSR bank request
    assign reg_req_if.dv    = req_dv & sel_reg;
    assign reg_req_if.write = req_write;
    assign reg_req_if.addr  = req_addr;
    assign reg_req_if.wdata = req_wdata;
    assign reg_req_if.user  = req_user;

    // SRAM controller request
    assign sram_req_if.dv    = req_dv & sel_sram;
    assign sram_req_if.write = req_write;
    assign sram_req_if.addr  = req_addr;
    assign sram_req_if.wdata = req_wdata;
    assign sram_req_if.user  = req_user;

    // Response return
    always_comb begin
        if (sel_reg) begin
            req_hold  = reg_req_if.hold;
            req_rdata = reg_req_if.rdata;
            req_error = reg_req_if.error;
        end else if (sel_sram) begin
            req_hold  = sram_req_if.hold;
            req_rdata = sram_req_if.rdata;
            req_error = sram_req_if.error;
        end else begin
            // Unmapped, complete at once with error
            req_hold  = 1'b0;
            req_rdata = '0;
            req_error = req_dv;
        end
    end

endmodule

`default_nettype wire

/* source/mci_top.sv */
////////////////////
// MCI subsystem top
// Fabric decoder, CSR bank, watchdog and
// MCU SRAM controller
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mci_top #(
    parameter  int MCU_SRAM_SIZE_KB = 4,
    localparam int SRAM_ADDR_W      = mci_pkg::sram_addr_w(MCU_SRAM_SIZE_KB)
) (
    input  logic                   clk,
    input  logic                   reset,

    // Fabric request port
    input  logic                   req_dv,
    input  logic                   req_write,
    input  mci_pkg::addr_t         req_addr,
    input  mci_pkg::data_t         req_wdata,
    input  mci_pkg::user_t         req_user,
    output logic                   req_hold,
    output mci_pkg::data_t         req_rdata,
    output logic                   req_error,

    // Straps
    input  mci_pkg::user_t         strap_mcu_user,
    input  mci_pkg::user_t         strap_clp_user,
    input  logic                   mcu_sram_fw_exec_region_lock,

    // MCU SRAM port
    output logic                   sram_cs,
    output logic                   sram_we,
    output logic [SRAM_ADDR_W-1:0] sram_addr,
    output mci_pkg::data_t         sram_wdata,
    input  mci_pkg::data_t         sram_rdata,

    // Interrupts
    output logic                   nmi_intr,
    output logic                   error_fatal
);
    import mci_pkg::*;

    // Privileged request flags
    logic mcu_req;
    logic clp_req;

    // Watchdog controls and status
    logic    t1_en;
    logic    t1_restart;
    logic    t2_restart;
    period_t t1_period;
    period_t t2_period;
    logic    t1_serviced;
    logic    t2_serviced;
    logic    t1_timeout;
    logic    t2_timeout;
    logic    t2_timeout_p;

    // Execution region size in KB
    data_t fw_exec_size;

    // Decoder to target buses
    cif_if reg_req_if ();
    cif_if sram_req_if ();

    mci_fabric_decode #(
        .MCU_SRAM_SIZE_KB(MCU_SRAM_SIZE_KB)
    ) i_mci_fabric_decode (
        .clk,
        .reset,
        .req_dv,
        .req_write,
        .req_addr,
        .req_wdata,
        .req_user,
        .req_hold,
        .req_rdata,
        .req_error,
        .strap_mcu_user,
        .strap_clp_user,
        .reg_req_if  (reg_req_if.request),
        .sram_req_if (sram_req_if.request),
        .mcu_req,
        .clp_req
    );

    // CSR bank
    mci_reg_top i_mci_reg_top (
        .clk,
        .reset,
        .cif_resp_if (reg_req_if.response),
        .mcu_req,
        .clp_req,
        .t1_en,
        .t1_restart,
        .t2_restart,
        .t1_period,
        .t2_period,
        .t1_serviced,
        .t2_serviced,
        .t1_timeout,
        .t2_timeout,
        .t2_timeout_p,
        .fw_exec_size,
        .error_fatal
    );

    // Cascaded watchdog, fatal drives the NMI
    mci_wdt_top i_mci_wdt_top (
        .clk,
        .reset,
        .t1_en,
        .t1_restart,
        .t2_restart,
        .t1_period,
        .t2_period,
        .t1_serviced,
        .t2_serviced,
        .t1_timeout,
        .t2_timeout,
        .t2_timeout_p,
        .fatal_timeout (nmi_intr)
    );

    mci_mcu_sram_ctrl #(
        .MCU_SRAM_SIZE_KB(MCU_SRAM_SIZE_KB)
    ) i_mci_mcu_sram_ctrl (
        .clk,
        .reset,
        .fw_exec_size,
        .mcu_req,
        .mcu_sram_fw_exec_region_lock,
        .cif_resp_if (sram_req_if.response),
        .sram_cs,
        .sram_we,
        .sram_addr,
        .sram_wdata,
        .sram_rdata
    );

endmodule

`default_nettype wire

/* tb/mci_top_props.sv */
////////////////////
// MCI top properties
// Fabric back-pressure, refused access and
// NMI stickiness checks, bound to mci_top
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mci_top_props (
    input logic clk,
    input logic reset,
    input logic req_hold,
    input logic req_error,
    input logic sram_cs,
    input logic nmi_intr
);

    // SRAM read stalls a single cycle
    hold_one_cycle: assert property (@(posedge clk) disable iff (reset)
        req_hold |=> !req_hold)
        else $error("req_hold high in two consecutive cycles");

    // Refused or unmapped access never reaches the SRAM
    no_cs_on_error: assert property (@(posedge clk) disable iff (reset)
        sram_cs |-> !req_error)
        else $error("sram_cs asserted together with req_error");

    // NMI is sticky until reset
    nmi_sticky: assert property (@(posedge clk) disable iff (reset)
        nmi_intr |=> nmi_intr)
        else $error("nmi_intr dropped without reset");

endmodule

bind mci_top mci_top_props i_mci_top_props (
    .clk       (clk),
    .reset     (reset),
    .req_hold  (req_hold),
    .req_error (req_error),
    .sram_cs   (sram_cs),
    .nmi_intr  (nmi_intr)
);

`default_nettype wire

/* tb/mci_top_tb.sv */
////////////////////
// MCI subsystem testbench
// SRAM traffic, exec region lock, CSR privilege,
// cascaded watchdog and fatal path
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mci_top_tb;
    import mci_pkg::*;

    localparam int    SRAM_KB     = 4;
    localparam int    SRAM_WORDS  = SRAM_KB * 256;
    localparam int    SRAM_AW     = $clog2(SRAM_WORDS);
    localparam addr_t SRAM_BYTES  = addr_t'(SRAM_KB * 1024);
    localparam user_t MCU_USER    = 8'h11;
    localparam user_t CLP_USER    = 8'h22;
    localparam int    N_RAND      = 40;
    // Upper bound on requests and idle waits
    localparam int    N_REQ       = 100;
    localparam int    WAIT_CYCLES = 100;
    localparam int    T1_PER      = 8;
    localparam int    T2_PER      = 5;

    // Expected response of one request
    typedef struct packed {
        logic  write;
        logic  error;
        logic  stall;
        logic  sram;
        data_t rdata;
    } resp_t;

    logic               clk;
    logic               reset;
    logic               req_dv;
    logic               req_write;
    addr_t              req_addr;
    data_t              req_wdata;
    user_t              req_user;
    logic               req_hold;
    data_t              req_rdata;
    logic               req_error;
    user_t              strap_mcu_user;
    user_t              strap_clp_user;
    logic               mcu_sram_fw_exec_region_lock;
    logic               sram_cs;
    logic               sram_we;
    logic [SRAM_AW-1:0] sram_addr;
    data_t              sram_wdata;
    data_t              sram_rdata;
    logic               nmi_intr;
    logic               error_fatal;

    data_t       sram_mem [SRAM_WORDS];
    data_t       sram_shadow [SRAM_WORDS];
    // Read view of the CSRs, index is offset / 4
    data_t       csr_shadow [8];
    resp_t       exp_q [$];
    logic [31:0] seed = 32'h073b_2990;

    mci_top #(.MCU_SRAM_SIZE_KB(SRAM_KB)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // SRAM model, read data one cycle after cs
    always @(posedge clk) begin
        if (sram_cs && sram_we) begin
            sram_mem[sram_addr] <= sram_wdata;
        end else if (sram_cs) begin
            sram_rdata <= sram_mem[sram_addr];
        end
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic data_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Any user that matches neither strap
    function automatic user_t other_user();
        user_t u;
        u = user_t'(next_rand() >> 24);
        if (u == MCU_USER || u == CLP_USER) begin
            u = 8'h5A;
        end
        return u;
    endfunction

    function automatic void reset_csr_shadow();
        foreach (csr_shadow[i]) begin
            csr_shadow[i] = '0;
        end
        // Both periods reset to all ones
        csr_shadow[2] = '1;
        csr_shadow[4] = '1;
    endfunction

    // Reference model of the address map and privilege rules
    function automatic resp_t expect_resp(logic write, addr_t addr, user_t user);
        resp_t e;
        logic  mcu;
        logic  priv;
        addr_t ofs;
        mcu     = (user == MCU_USER);
        priv    = mcu || (user == CLP_USER);
        e       = '0;
        e.write = write;
        if (addr < REG_SIZE) begin
            e.error = write && !priv;
            if (addr < 32'h20) begin
                e.rdata = csr_shadow[addr[4:2]];
            end
        end else if (addr >= SRAM_BASE && addr < SRAM_BASE + SRAM_BYTES) begin
            ofs = addr - SRAM_BASE;
            // Region size is given in KB
            if (mcu_sram_fw_exec_region_lock && !mcu && ofs < csr_shadow[6] * 32'd1024) begin
                e.error = 1'b1;
            end else begin
                e.sram = 1'b1;
                if (!write) begin
                    e.rdata = sram_shadow[ofs[SRAM_AW+1:2]];
                    e.stall = 1'b1;
                end
            end
        end else begin
            e.error = 1'b1;
        end
        return e;
    endfunction

    // Effect of a completed write on the shadows
    function automatic void apply_write(resp_t e, addr_t addr, data_t wdata);
        if (e.write && !e.error && addr < REG_SIZE) begin
            case (addr)
                WDT_T1_EN_OFS:      csr_shadow[0] = {31'd0, wdata[0]};
                WDT_T1_PERIOD_OFS:  csr_shadow[2] = wdata;
                WDT_T2_PERIOD_OFS:  csr_shadow[4] = wdata;
                WDT_STATUS_OFS:     csr_shadow[5] = csr_shadow[5] & ~{30'd0, wdata[1:0]};
                FW_EXEC_SIZE_OFS:   csr_shadow[6] = wdata;
                HW_ERROR_FATAL_OFS: csr_shadow[7] = csr_shadow[7] & ~{31'd0, wdata[0]};
                default: ;
            endcase
        end else if (e.write && !e.error) begin
            sram_shadow[(addr - SRAM_BASE) >> 2] = wdata;
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) next_cycle();
        reset = 1'b0;
        reset_csr_shadow();
    endtask

    // One fabric request, waits for completion
    task automatic access(input logic write, input addr_t addr, input data_t wdata,
                          input user_t user);
        resp_t e;
        int    stalls;
        e = expect_resp(write, addr, user);
        exp_q.push_back(e);
        req_dv    = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_user  = user;
        stalls    = 0;
        @(negedge clk);
        while (req_hold) begin
            stalls++;
            if (stalls > 4) begin
                $display("ERROR: request to 0x%08h never completed", addr);
                stop_run();
            end
            @(negedge clk);
        end
        apply_write(e, addr, wdata);
        next_cycle();
        req_dv = 1'b0;
    endtask

    // Checks every fabric cycle against the queued expectation
    initial begin : compare_responses
        resp_t e;
        int    hold_cycles;
        hold_cycles = 0;
        forever begin
            @(negedge clk);
            if (!reset && req_dv) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: request active with no expected response");
                    stop_run();
                end
                e = exp_q[0];
                // SRAM strobes only in the first cycle of an SRAM access
                check_flag("sram_cs", sram_cs, e.sram && hold_cycles == 0);
                check_flag("sram_we", sram_we, e.sram && e.write && hold_cycles == 0);
                // Reads hold exactly one cycle
                check_flag("req_hold", req_hold, e.stall && hold_cycles == 0);
                if (req_hold) begin
                    hold_cycles++;
                end else begin
                    check_flag("req_error", req_error, e.error);
                    if (!e.write) begin
                        check_data("req_rdata", req_rdata, e.rdata);
                    end
                    void'(exp_q.pop_front());
                    hold_cycles = 0;
                end
            end
        end
    end

    initial begin : run_watchdog
        repeat (N_REQ * 3 + WAIT_CYCLES) @(posedge clk);
        $display("ERROR: simulation timed out before all tests finished");
        stop_run();
    end

    initial begin : run_tests
        data_t r;
        int    waited;
        reset                        = 1'b1;
        req_dv                       = 1'b0;
        req_write                    = 1'b0;
        req_addr                     = '0;
        req_wdata                    = '0;
        req_user                     = '0;
        strap_mcu_user               = MCU_USER;
        strap_clp_user               = CLP_USER;
        mcu_sram_fw_exec_region_lock = 1'b0;
        sram_rdata                   <= '0;
        // Fill pattern over the whole word address
        for (int i = 0; i < SRAM_WORDS; i++) begin
            sram_mem[i]    <= data_t'((i + 1) * 32'h9E37_79B9);
            sram_shadow[i] = data_t'((i + 1) * 32'h9E37_79B9);
        end
        reset_csr_shadow();
        apply_reset();

        // Random MCU traffic over 64 words, lock clear
        repeat (N_RAND) begin
            r = next_rand();
            access(r[0], SRAM_BASE + addr_t'({r[13:8], 2'b00}), next_rand(), MCU_USER);
        end

        // Exec region of 1 KB under lock
        access(1'b1, FW_EXEC_SIZE_OFS, 32'd1, MCU_USER);
        mcu_sram_fw_exec_region_lock = 1'b1;
        access(1'b1, SRAM_BASE + 32'h10, 32'hDEAD_BEEF, CLP_USER);
        access(1'b0, SRAM_BASE + 32'h10, '0, CLP_USER);
        access(1'b1, SRAM_BASE + 32'h3FC, 32'h1234_5678, other_user());
        access(1'b0, SRAM_BASE + 32'h3FC, '0, other_user());
        // Contents must be untouched
        access(1'b0, SRAM_BASE + 32'h10, '0, MCU_USER);
        access(1'b0, SRAM_BASE + 32'h3FC, '0, MCU_USER);
        access(1'b1, SRAM_BASE + 32'h10, next_rand(), MCU_USER);
        access(1'b0, SRAM_BASE + 32'h10, '0, MCU_USER);
        // Above the region anyone may access
        access(1'b1, SRAM_BASE + 32'h400, next_rand(), other_user());
        access(1'b0, SRAM_BASE + 32'h400, '0, other_user());
        access(1'b0, SRAM_BASE + 32'h800, '0, CLP_USER);
        mcu_sram_fw_exec_region_lock = 1'b0;

        // CSR privilege
        access(1'b1, WDT_T1_PERIOD_OFS, next_rand(), MCU_USER);
        access(1'b0, WDT_T1_PERIOD_OFS, '0, other_user());
        access(1'b1, WDT_T2_PERIOD_OFS, next_rand(), CLP_USER);
        access(1'b0, WDT_T2_PERIOD_OFS, '0, CLP_USER);
        access(1'b1, WDT_T1_PERIOD_OFS, next_rand(), other_user());
        access(1'b0, WDT_T1_PERIOD_OFS, '0, MCU_USER);
        access(1'b1, WDT_T1_CTRL_OFS, 32'd1, MCU_USER);
        access(1'b0, WDT_T1_CTRL_OFS, '0, MCU_USER);
        // Hole in the CSR window, then unmapped space
        access(1'b0, 32'h0000_0040, '0, other_user());
        access(1'b0, 32'h0000_8000, '0, MCU_USER);
        access(1'b1, 32'h0002_0000, next_rand(), MCU_USER);

        // Stage 1 kept alive by restarts
        access(1'b1, WDT_T1_PERIOD_OFS, T1_PER, MCU_USER);
        access(1'b1, WDT_T1_EN_OFS, 32'd1, MCU_USER);
        repeat (6) begin
            access(1'b1, WDT_T1_CTRL_OFS, 32'd1, MCU_USER);
            repeat (3) next_cycle();
        end
        access(1'b0, WDT_STATUS_OFS, '0, MCU_USER);
        // Left alone it expires
        repeat (T1_PER + 3) next_cycle();
        csr_shadow[5][0] = 1'b1;
        access(1'b0, WDT_STATUS_OFS, '0, MCU_USER);
        access(1'b1, WDT_STATUS_OFS, 32'd1, MCU_USER);
        access(1'b0, WDT_STATUS_OFS, '0, MCU_USER);
        access(1'b1, WDT_T1_EN_OFS, 32'd0, MCU_USER);

        // Unserviced cascade reaches NMI
        access(1'b1, WDT_T2_PERIOD_OFS, T2_PER, MCU_USER);
        access(1'b1, WDT_T1_EN_OFS, 32'd1, MCU_USER);
        waited = 0;
        while (!nmi_intr) begin
            if (waited == T1_PER + T2_PER + 4) begin
                $display("ERROR: nmi_intr did not rise after the stage 2 timeout");
                stop_run();
            end
            next_cycle();
            waited++;
        end
        csr_shadow[5] = 32'd3;
        csr_shadow[7] = 32'd1;
        check_flag("error_fatal", error_fatal, 1'b1);
        access(1'b0, WDT_STATUS_OFS, '0, CLP_USER);
        access(1'b0, HW_ERROR_FATAL_OFS, '0, MCU_USER);
        access(1'b1, HW_ERROR_FATAL_OFS, 32'd1, MCU_USER);
        access(1'b0, HW_ERROR_FATAL_OFS, '0, MCU_USER);
        check_flag("error_fatal", error_fatal, 1'b0);
        check_flag("nmi_intr", nmi_intr, 1'b1);
        // Only reset drops the NMI
        apply_reset();
        check_flag("nmi_intr", nmi_intr, 1'b0);
        check_flag("error_fatal", error_fatal, 1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
